// ==== include/noc_defines.svh ====
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// Router geometry

// Input and output ports, port 0 is the local port
`define NOC_NUM_PORTS 4

// Node id of this router
`define NOC_NODE_ID 4'd5

// Flits held per input FIFO
`define NOC_FIFO_DEPTH 4

// One route entry per destination node
`define NOC_TABLE_SIZE 16

`endif

// ==== verilog/noc_pkg.sv ====
package noc_pkg;

    // Flit format opcode
    typedef enum logic [1:0] {
        FMT_DATA = 2'd0,
        FMT_CFG  = 2'd1
    } flit_fmt_e;

    // Single-flit packet
    // For FMT_CFG, payload[3:0] is the table index and payload[5:4] the new port
    typedef struct packed {
        flit_fmt_e   fmt;
        logic [3:0]  dest;
        logic [25:0] payload;
    } flit_t;

    // Head-of-line state of one input buffer
    typedef enum logic [1:0] {
        BUF_EMPTY,
        BUF_ROUTE,
        BUF_SWITCH
    } buf_state_e;

    // Output port index
    typedef logic [1:0] port_idx_t;

endpackage

// ==== verilog/noc_req_if.sv ====
`timescale 1ns/1ns

`include "noc_defines.svh"

interface noc_req_if import noc_pkg::*; ();

    // Head of each input FIFO
    flit_t     [`NOC_NUM_PORTS-1:0] head_flit;

    // Route compute handshake
    logic      [`NOC_NUM_PORTS-1:0] rc_req;
    logic      [`NOC_NUM_PORTS-1:0] rc_grant;
    port_idx_t                      rc_outport;
    logic                           rc_claim;

    // Switch allocation handshake, indexed by input
    logic      [`NOC_NUM_PORTS-1:0] sa_req;
    port_idx_t [`NOC_NUM_PORTS-1:0] sa_outport;
    logic      [`NOC_NUM_PORTS-1:0] sa_grant;

    // Crossbar control, indexed by output
    port_idx_t [`NOC_NUM_PORTS-1:0] xb_sel;
    logic      [`NOC_NUM_PORTS-1:0] xb_enable;

    modport buffers (
        output head_flit, rc_req, sa_req, sa_outport,
        input  rc_grant, rc_outport, rc_claim, sa_grant
    );

    modport route (
        input  head_flit, rc_req,
        output rc_grant, rc_outport, rc_claim
    );

    modport alloc (
        input  sa_req, sa_outport,
        output sa_grant, xb_sel, xb_enable
    );

    modport xbar (
        input head_flit, xb_sel, xb_enable
    );

endinterface

// ==== verilog/rr_arbiter.sv ====
`timescale 1ns/1ns

module rr_arbiter import noc_pkg::*; #(
    parameter int WIDTH = 4
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] req,
    output logic [WIDTH-1:0] grant,
    output port_idx_t        grant_idx,
    output logic             grant_valid
);

    // Requester with highest priority this cycle
    port_idx_t ptr;

    // First requester at or after the pointer wins
    always_comb begin
        int idx;
        grant       = '0;
        grant_idx   = '0;
        grant_valid = 1'b0;
        for (int i = 0; i < WIDTH; i++) begin
            idx = (int'(ptr) + i) % WIDTH;
            if (!grant_valid && req[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = port_idx_t'(idx);
            end
        end
        if (grant_valid) begin
            grant[grant_idx] = 1'b1;
        end
    end

    // Rotate past the winner
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (grant_valid) begin
            if (int'(grant_idx) == WIDTH - 1) begin
                ptr <= '0;
            end else begin
                ptr <= grant_idx + port_idx_t'(1);
            end
        end
    end

endmodule

// ==== verilog/input_buffers.sv ====
`timescale 1ns/1ns

`include "noc_defines.svh"

module input_buffers import noc_pkg::*; (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic  [`NOC_NUM_PORTS-1:0]     in_valid,
    input  flit_t [`NOC_NUM_PORTS-1:0]     in_flit,
    output logic  [`NOC_NUM_PORTS-1:0]     buffer_available,
    noc_req_if.buffers                     req
);

    localparam int NP    = `NOC_NUM_PORTS;
    localparam int DEPTH = `NOC_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    flit_t            mem [NP][DEPTH];
    logic [PTR_W-1:0] wr_ptr [NP];
    logic [PTR_W-1:0] rd_ptr [NP];
    logic [CNT_W-1:0] count [NP];
    buf_state_e       state [NP];
    port_idx_t        route_port [NP];

    logic [NP-1:0] push;
    logic [NP-1:0] pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (int'(ptr) == DEPTH - 1) begin
            return '0;
        end
        return ptr + PTR_W'(1);
    endfunction

    always_comb begin
        for (int p = 0; p < NP; p++) begin
            buffer_available[p] = (count[p] != CNT_W'(DEPTH));
            push[p]             = in_valid[p] && buffer_available[p];
            // Claimed config flits leave from ROUTE, everything else from SWITCH
            pop[p] = (state[p] == BUF_ROUTE && req.rc_grant[p] && req.rc_claim) ||
                     (state[p] == BUF_SWITCH && req.sa_grant[p]);
            req.head_flit[p]  = mem[p][rd_ptr[p]];
            req.rc_req[p]     = (state[p] == BUF_ROUTE);
            req.sa_req[p]     = (state[p] == BUF_SWITCH);
            req.sa_outport[p] = route_port[p];
        end
    end

    // FIFO storage and stored route result
    always_ff @(posedge clk) begin
        for (int p = 0; p < NP; p++) begin
            if (push[p]) begin
                mem[p][wr_ptr[p]] <= in_flit[p];
            end
            if (state[p] == BUF_ROUTE && req.rc_grant[p]) begin
                route_port[p] <= req.rc_outport;
            end
        end
    end

    // Pointers, counts and head FSMs
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int p = 0; p < NP; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
                count[p]  <= '0;
                state[p]  <= BUF_EMPTY;
            end
        end else begin
            for (int p = 0; p < NP; p++) begin
                if (push[p]) begin
                    wr_ptr[p] <= next_ptr(wr_ptr[p]);
                end
                if (pop[p]) begin
                    rd_ptr[p] <= next_ptr(rd_ptr[p]);
                end
                count[p] <= count[p] + CNT_W'(push[p]) - CNT_W'(pop[p]);

                case (state[p])
                    BUF_EMPTY: begin
                        if (count[p] != '0) begin
                            state[p] <= BUF_ROUTE;
                        end
                    end
                    BUF_ROUTE: begin
                        if (req.rc_grant[p]) begin
                            state[p] <= req.rc_claim ? BUF_EMPTY : BUF_SWITCH;
                        end
                    end
                    BUF_SWITCH: begin
                        if (req.sa_grant[p]) begin
                            state[p] <= BUF_EMPTY;
                        end
                    end
                    default: state[p] <= BUF_EMPTY;
                endcase
            end
        end
    end

endmodule

// ==== verilog/route_compute.sv ====
`timescale 1ns/1ns

`include "noc_defines.svh"

module route_compute import noc_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    noc_req_if.route req
);

    logic [`NOC_NUM_PORTS-1:0] grant;
    port_idx_t                 sel;
    logic                      sel_valid;
    flit_t                     head;
    logic                      cfg_hit;

    port_idx_t route_table [`NOC_TABLE_SIZE];

    // Local dest goes to port 0, others spread over ports 1 to 3
    function automatic port_idx_t reset_route(input int dest);
        if (dest == int'(`NOC_NODE_ID)) begin
            return port_idx_t'(0);
        end
        return port_idx_t'(1 + dest % 3);
    endfunction

    // One head is served per cycle
    rr_arbiter #(
        .WIDTH(`NOC_NUM_PORTS)
    ) rc_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req.rc_req),
        .grant      (grant),
        .grant_idx  (sel),
        .grant_valid(sel_valid)
    );

    assign head    = req.head_flit[sel];
    assign cfg_hit = sel_valid && head.fmt == FMT_CFG && head.dest == `NOC_NODE_ID;

    assign req.rc_grant   = grant;
    assign req.rc_claim   = cfg_hit;
    assign req.rc_outport = route_table[head.dest];

    // Table rewrite at the edge the config flit is claimed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `NOC_TABLE_SIZE; i++) begin
                route_table[i] <= reset_route(i);
            end
        end else if (cfg_hit) begin
            route_table[head.payload[3:0]] <= head.payload[5:4];
        end
    end

endmodule

// ==== verilog/switch_allocator.sv ====
`timescale 1ns/1ns

`include "noc_defines.svh"

module switch_allocator import noc_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    noc_req_if.alloc req
);

    localparam int NP = `NOC_NUM_PORTS;

    // Per-output request and grant vectors, indexed by input
    logic [NP-1:0] out_req   [NP];
    logic [NP-1:0] out_grant [NP];
    port_idx_t     out_sel   [NP];
    logic [NP-1:0] out_valid;

    always_comb begin
        for (int o = 0; o < NP; o++) begin
            for (int i = 0; i < NP; i++) begin
                out_req[o][i] = req.sa_req[i] && (int'(req.sa_outport[i]) == o);
            end
        end
    end

    for (genvar o = 0; o < NP; o++) begin : g_out
        rr_arbiter #(
            .WIDTH(NP)
        ) sa_arb (
            .clk        (clk),
            .rst_n      (rst_n),
            .req        (out_req[o]),
            .grant      (out_grant[o]),
            .grant_idx  (out_sel[o]),
            .grant_valid(out_valid[o])
        );
    end

    // An input requests one output, so at most one grant reaches it
    always_comb begin
        req.sa_grant = '0;
        for (int o = 0; o < NP; o++) begin
            req.sa_grant  = req.sa_grant | out_grant[o];
            req.xb_sel[o] = out_sel[o];
        end
        req.xb_enable = out_valid;
    end

endmodule

// ==== verilog/crossbar.sv ====
`timescale 1ns/1ns

`include "noc_defines.svh"

module crossbar import noc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    noc_req_if.xbar                    req,
    output logic  [`NOC_NUM_PORTS-1:0] out_valid,
    output flit_t [`NOC_NUM_PORTS-1:0] out_flit
);

    localparam int NP = `NOC_NUM_PORTS;

    // Strobe follows the grant by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= req.xb_enable;
        end
    end

    // Flit register per output, loaded only on a grant
    always_ff @(posedge clk) begin
        for (int o = 0; o < NP; o++) begin
            if (req.xb_enable[o]) begin
                out_flit[o] <= req.head_flit[req.xb_sel[o]];
            end
        end
    end

endmodule

// ==== verilog/noc_switch.sv ====
`timescale 1ns/1ns

`include "noc_defines.svh"

module noc_switch import noc_pkg::*; (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic  [`NOC_NUM_PORTS-1:0] in_valid,
    input  flit_t [`NOC_NUM_PORTS-1:0] in_flit,
    output logic  [`NOC_NUM_PORTS-1:0] buffer_available,
    output logic  [`NOC_NUM_PORTS-1:0] out_valid,
    output flit_t [`NOC_NUM_PORTS-1:0] out_flit
);

    // Shared request bus between the pipeline stages
    noc_req_if req_if ();

    // Input FIFOs and head FSMs
    input_buffers buffers_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_flit         (in_flit),
        .buffer_available(buffer_available),
        .req             (req_if.buffers)
    );

    // Stage 1: route lookup and config claim
    route_compute route_inst (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req_if.route)
    );

    // Stage 2: output arbitration
    switch_allocator alloc_inst (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (req_if.alloc)
    );

    // Stage 3: crossbar traversal
    crossbar xbar_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (req_if.xbar),
        .out_valid(out_valid),
        .out_flit (out_flit)
    );

endmodule

// ==== dv/noc_switch_assertions.sv ====
`timescale 1ns/1ns

`include "noc_defines.svh"

module noc_switch_assertions import noc_pkg::*; (
    input logic                           clk,
    input logic                           rst_n,
    input logic      [`NOC_NUM_PORTS-1:0] in_valid,
    input logic      [`NOC_NUM_PORTS-1:0] buffer_available,
    input logic      [`NOC_NUM_PORTS-1:0] out_valid,
    input logic      [`NOC_NUM_PORTS-1:0] sa_grant,
    input port_idx_t [`NOC_NUM_PORTS-1:0] sa_outport,
    input logic      [`NOC_NUM_PORTS-1:0] xb_enable
);

    // Granted inputs per output, as seen from the buffers' stored routes
    logic [`NOC_NUM_PORTS-1:0] granted_to [`NOC_NUM_PORTS];

    always_comb begin
        for (int o = 0; o < `NOC_NUM_PORTS; o++) begin
            for (int i = 0; i < `NOC_NUM_PORTS; i++) begin
                granted_to[o][i] = sa_grant[i] && (int'(sa_outport[i]) == o);
            end
        end
    end

    // An enabled output takes exactly one input, an idle one none
    for (genvar o = 0; o < `NOC_NUM_PORTS; o++) begin : g_grant
        grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            (xb_enable[o] ? $onehot(granted_to[o]) : (granted_to[o] == '0)))
            else $error("Output %0d grant is not one-hot or disagrees with its enable", o);
    end

    // Sender has to hold off while a FIFO is full
    no_write_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid & ~buffer_available) == '0)
        else $error("Write to a full input FIFO");

    quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> out_valid == '0)
        else $error("Output strobe right after reset");

endmodule

bind noc_switch noc_switch_assertions assertions_inst (
    .clk             (clk),
    .rst_n           (rst_n),
    .in_valid        (in_valid),
    .buffer_available(buffer_available),
    .out_valid       (out_valid),
    .sa_grant        (req_if.sa_grant),
    .sa_outport      (req_if.sa_outport),
    .xb_enable       (req_if.xb_enable)
);

// ==== dv/noc_switch_tb.sv ====
`timescale 1ns/1ns

`include "noc_defines.svh"

module noc_switch_tb import noc_pkg::*; ();

    localparam int NP         = `NOC_NUM_PORTS;
    localparam int RAND_STEPS = 60;
    localparam int HOT_STEPS  = 20;
    localparam int MAX_FLITS  = 16 + 4 + NP * (RAND_STEPS + HOT_STEPS);
    localparam int LIMIT      = 20 * MAX_FLITS + 200;

    logic           clk;
    logic           rst_n;
    logic  [NP-1:0] in_valid;
    flit_t [NP-1:0] in_flit;
    logic  [NP-1:0] buffer_available;
    logic  [NP-1:0] out_valid;
    flit_t [NP-1:0] out_flit;

    // Shadow route table and per (input, output) expected flits
    port_idx_t shadow [`NOC_TABLE_SIZE];
    flit_t     exp_q [NP*NP][$];
    flit_t     stage [NP];
    int        sent_to [NP];
    int        strobes [NP];
    int        seq;

    noc_switch noc_switch_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_flit         (in_flit),
        .buffer_available(buffer_available),
        .out_valid       (out_valid),
        .out_flit        (out_flit)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic port_idx_t expected_port(input flit_t f);
        return shadow[f.dest];
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        if (actual !== expected) begin
            $display("FAIL %0t: %s, got %h expected %h", $time, what, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Payload tag is the input port over a running sequence number
    function automatic flit_t make_flit(input flit_fmt_e fmt, input int p, input int dest);
        flit_t f;
        f.fmt     = fmt;
        f.dest    = 4'(dest);
        f.payload = {2'(p), 24'(seq)};
        seq++;
        return f;
    endfunction

    // Claimed config flits only rewrite the shadow table
    task automatic record(input int p, input flit_t f);
        port_idx_t o;
        if (f.fmt == FMT_CFG && f.dest == `NOC_NODE_ID) begin
            shadow[f.payload[3:0]] = f.payload[5:4];
        end else begin
            o = expected_port(f);
            exp_q[p*NP + int'(o)].push_back(f);
            sent_to[o]++;
        end
    endtask

    // One strobe cycle then one idle cycle, so buffer_available is current
    task automatic issue(input logic [NP-1:0] mask);
        @(posedge clk);
        for (int p = 0; p < NP; p++) begin
            if (mask[p] && buffer_available[p]) begin
                in_valid[p] <= 1'b1;
                in_flit[p]  <= stage[p];
                record(p, stage[p]);
            end
        end
        @(posedge clk);
        in_valid <= '0;
    endtask

    function automatic int pending();
        int n;
        n = 0;
        for (int i = 0; i < NP*NP; i++) begin
            n += exp_q[i].size();
        end
        return n;
    endfunction

    always @(posedge clk) begin
        int    idx;
        flit_t want;
        if (rst_n) begin
            for (int o = 0; o < NP; o++) begin
                if (out_valid[o]) begin
                    idx = int'(out_flit[o].payload[25:24]) * NP + o;
                    strobes[o]++;
                    check(exp_q[idx].size() != 0, 1, $sformatf("unexpected flit on output %0d", o));
                    want = exp_q[idx].pop_front();
                    check(out_flit[o], want, $sformatf("flit on output %0d", o));
                end
            end
        end
    end

    initial begin
        repeat (LIMIT) @(posedge clk);
        $display("Timeout: flits still undelivered after %0d cycles", LIMIT);
        $display("TESTS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        flit_t f;
        void'($urandom(32'h1060));
        rst_n    = 1'b0;
        in_valid = '0;
        in_flit  = '0;
        seq      = 0;
        for (int d = 0; d < `NOC_TABLE_SIZE; d++) begin
            shadow[d] = (d == int'(`NOC_NODE_ID)) ? port_idx_t'(0) : port_idx_t'(1 + d % 3);
        end
        for (int p = 0; p < NP; p++) begin
            sent_to[p] = 0;
            strobes[p] = 0;
        end
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check(out_valid, '0, "out_valid after reset");
        check(buffer_available, {NP{1'b1}}, "buffer_available after reset");

        for (int d = 0; d < `NOC_TABLE_SIZE; d++) begin
            stage[d % NP] = make_flit(FMT_DATA, d % NP, d);
            issue(NP'(1) << (d % NP));
        end
        while (pending() != 0) @(posedge clk);

        // Point dest 3 at port 2, then use the new entry
        f = make_flit(FMT_CFG, 1, int'(`NOC_NODE_ID));
        f.payload[5:0] = {2'd2, 4'd3};
        stage[1] = f;
        issue(NP'(2));
        repeat (10) @(posedge clk);
        stage[2] = make_flit(FMT_DATA, 2, 3);
        issue(NP'(4));
        stage[3] = make_flit(FMT_CFG, 3, 7);
        issue(NP'(8));
        while (pending() != 0) @(posedge clk);

        for (int s = 0; s < RAND_STEPS; s++) begin
            for (int p = 0; p < NP; p++) begin
                stage[p] = make_flit(FMT_DATA, p, $urandom_range(15, 0));
            end
            issue(NP'($urandom));
        end
        while (pending() != 0) @(posedge clk);

        // Every input aims at dest 0, all on one output
        for (int s = 0; s < HOT_STEPS; s++) begin
            for (int p = 0; p < NP; p++) begin
                stage[p] = make_flit(FMT_DATA, p, 0);
            end
            issue('1);
        end
        while (pending() != 0) @(posedge clk);
        repeat (5) @(posedge clk);
        for (int o = 0; o < NP; o++) begin
            check(strobes[o], sent_to[o], $sformatf("strobe count on output %0d", o));
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== noc_switch.f ====
+incdir+include
verilog/noc_pkg.sv
verilog/noc_req_if.sv
verilog/rr_arbiter.sv
verilog/input_buffers.sv
verilog/route_compute.sv
verilog/switch_allocator.sv
verilog/crossbar.sv
verilog/noc_switch.sv
dv/noc_switch_assertions.sv
dv/noc_switch_tb.sv

// ==== Makefile ====
TOP = noc_switch_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -j 0 -f noc_switch.f --top-module $(TOP) -o sim
	./obj_dir/sim | tee sim.log
	! grep -q "TESTS FAILED" sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -f noc_switch.f --top-module noc_switch

clean:
	rm -rf obj_dir sim.log
